/* src/board_pkg.sv */
// Board subsystem shared types
package board_pkg;

  // ==================================================
  // Display and IO widths
  // ==================================================

  // Active low, bit 0 drives segment a
  typedef logic [6:0]  seg_t;
  typedef logic [3:0]  nibble_t;
  typedef logic [23:0] value_t;

  typedef logic [7:0]  arg_t;
  typedef logic [9:0]  sw_t;
  typedef logic [3:0]  key_t;
  typedef logic [9:0]  led_t;

  // Saturates at 255
  typedef logic [7:0]  drop_cnt_t;

  // ==================================================
  // Encodings
  // ==================================================

  typedef enum logic [1:0] {
    op_shift,
    op_add,
    op_clear
  } cmd_op_t;

  typedef enum logic [1:0] {
    released,
    press_wait,
    pressed,
    release_wait
  } deb_state_t;

endpackage

/* src/hex_decoder.sv */
// Hex digit to seven segment glyph
`timescale 1ns/10ps

module hex_decoder import board_pkg::*; (
  input  nibble_t digit,
  output seg_t    seg
);

  // Patterns are gfedcba, a zero lights the segment
  always_comb begin
    case (digit)
      4'h0:    seg = 7'h40;
      4'h1:    seg = 7'h79;
      4'h2:    seg = 7'h24;
      4'h3:    seg = 7'h30;
      4'h4:    seg = 7'h19;
      4'h5:    seg = 7'h12;
      4'h6:    seg = 7'h02;
      4'h7:    seg = 7'h78;
      4'h8:    seg = 7'h00;
      4'h9:    seg = 7'h10;
      4'ha:    seg = 7'h08;
      4'hb:    seg = 7'h03;
      4'hc:    seg = 7'h46;
      4'hd:    seg = 7'h21;
      4'he:    seg = 7'h06;
      default: seg = 7'h0e;
    endcase
  end

endmodule

/* src/reset_sync.sv */
// System reset generator
`timescale 1ns/10ps

module reset_sync (
  input  logic clk,
  input  logic rst_n,
  input  logic button_rst_n,
  input  logic pll_locked,
  output logic sys_rst_n
);

  // Any source low forces reset immediately
  logic       arst_n;
  logic [1:0] sync_q;

  assign arst_n = rst_n & button_rst_n & pll_locked;

  // Ones shift in after release, so deassertion lands on a clock edge
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      sync_q <= 2'b00;
    end else begin
      sync_q <= {sync_q[0], 1'b1};
    end
  end

  assign sys_rst_n = sync_q[1];

endmodule

/* src/key_debounce.sv */
// Push button debouncer
`timescale 1ns/10ps

module key_debounce import board_pkg::*; #(
  parameter int DEBOUNCE_CYCLES = 500000
) (
  input  logic clk,
  input  logic rst_n,
  input  logic key_n,
  output logic press
);

  localparam int CNT_W = $clog2(DEBOUNCE_CYCLES);
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(DEBOUNCE_CYCLES - 1);

  logic             key_meta;
  logic             key_sync;
  logic             key_low;
  logic [CNT_W-1:0] cnt;
  deb_state_t       state;

  // Two flop synchronizer, idles high like the released key
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      key_meta <= 1'b1;
      key_sync <= 1'b1;
    end else begin
      key_meta <= key_n;
      key_sync <= key_meta;
    end
  end

  assign key_low = ~key_sync;

  // ==================================================
  // Stable level FSM
  // ==================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= released;
      cnt   <= '0;
      press <= 1'b0;
    end else begin
      press <= 1'b0;
      case (state)
        released: begin
          if (key_low) begin
            state <= press_wait;
            cnt   <= CNT_W'(1);
          end
        end
        press_wait: begin
          if (!key_low) begin
            state <= released;
          end else if (cnt == CNT_LAST) begin
            state <= pressed;
            press <= 1'b1;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        pressed: begin
          if (!key_low) begin
            state <= release_wait;
            cnt   <= CNT_W'(1);
          end
        end
        release_wait: begin
          // A bounce back low keeps the key held, no second pulse
          if (key_low) begin
            state <= pressed;
          end else if (cnt == CNT_LAST) begin
            state <= released;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        default: state <= released;
      endcase
    end
  end

endmodule

/* src/cmd_issuer.sv */
// Key command issuer
`timescale 1ns/10ps

module cmd_issuer import board_pkg::*; #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      press_shift,
  input  logic      press_add,
  input  logic      press_clear,
  input  sw_t       sw,
  input  logic      credit_return,
  output logic      cmd_valid,
  output cmd_op_t   cmd_op,
  output arg_t      cmd_arg,
  output drop_cnt_t drop_cnt
);

  localparam int CRED_W = $clog2(FIFO_DEPTH + 1);

  logic [CRED_W-1:0] credits;
  logic              any_press;
  logic              issue;
  logic [1:0]        n_press;
  logic [1:0]        n_drop;
  logic [8:0]        drop_sum;
  cmd_op_t           sel_op;
  arg_t              sel_arg;

  assign any_press = press_shift | press_add | press_clear;
  assign issue     = any_press && (credits != '0);

  // Every press that is not issued counts as a drop
  assign n_press  = 2'(press_shift) + 2'(press_add) + 2'(press_clear);
  assign n_drop   = issue ? n_press - 2'd1 : n_press;
  assign drop_sum = {1'b0, drop_cnt} + 9'(n_drop);

  // Priority shift, add, clear
  always_comb begin
    if (press_shift) begin
      sel_op  = op_shift;
      sel_arg = {4'b0000, sw[3:0]};
    end else if (press_add) begin
      sel_op  = op_add;
      sel_arg = sw[7:0];
    end else begin
      sel_op  = op_clear;
      sel_arg = '0;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      credits   <= CRED_W'(FIFO_DEPTH);
      cmd_valid <= 1'b0;
      drop_cnt  <= '0;
    end else begin
      // Return and spend may land on the same edge
      credits   <= credits + CRED_W'(credit_return) - CRED_W'(issue);
      cmd_valid <= issue;
      drop_cnt  <= drop_sum[8] ? 8'hff : drop_sum[7:0];
    end
  end

  always_ff @(posedge clk) begin
    if (issue) begin
      cmd_op  <= sel_op;
      cmd_arg <= sel_arg;
    end
  end

endmodule

/* src/display_engine.sv */
// Seven segment display engine
`timescale 1ns/10ps

module display_engine import board_pkg::*; #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      freeze,
  input  logic      cmd_valid,
  input  cmd_op_t   cmd_op,
  input  arg_t      cmd_arg,
  input  drop_cnt_t drop_cnt,
  output logic      credit_return,
  output seg_t      hex0,
  output seg_t      hex1,
  output seg_t      hex2,
  output seg_t      hex3,
  output seg_t      hex4,
  output seg_t      hex5,
  output led_t      ledr
);

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  cmd_op_t          op_mem  [FIFO_DEPTH];
  arg_t             arg_mem [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             empty;
  logic             pop;
  value_t           value;
  seg_t             seg [6];

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(FIFO_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // ==================================================
  // Command queue
  // ==================================================

  // Issuer credits guarantee a free slot on every write
  always_ff @(posedge clk) begin
    if (cmd_valid) begin
      op_mem[wr_ptr]  <= cmd_op;
      arg_mem[wr_ptr] <= cmd_arg;
    end
  end

  assign empty         = (count == '0);
  assign pop           = !freeze && !empty;
  assign credit_return = pop;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (cmd_valid) wr_ptr <= next_ptr(wr_ptr);
      if (pop) rd_ptr <= next_ptr(rd_ptr);
      count <= count + CNT_W'(cmd_valid) - CNT_W'(pop);
    end
  end

  // ==================================================
  // Value register and drive
  // ==================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      value <= '0;
    end else if (pop) begin
      case (op_mem[rd_ptr])
        op_shift: value <= {value[19:0], arg_mem[rd_ptr][3:0]};
        op_add:   value <= value + value_t'(arg_mem[rd_ptr]);
        op_clear: value <= '0;
        default:  value <= value;
      endcase
    end
  end

  // Digit 0 is the lowest nibble
  for (genvar i = 0; i < 6; i++) begin : g_digit
    hex_decoder u_hex_decoder (
      .digit (value[4*i +: 4]),
      .seg   (seg[i])
    );
  end

  assign hex0 = seg[0];
  assign hex1 = seg[1];
  assign hex2 = seg[2];
  assign hex3 = seg[3];
  assign hex4 = seg[4];
  assign hex5 = seg[5];

  assign ledr = {freeze, !empty, drop_cnt};

endmodule

/* src/board_top.sv */
// Board subsystem top level
`timescale 1ns/10ps

module board_top import board_pkg::*; #(
  parameter int DEBOUNCE_CYCLES = 500000,
  parameter int FIFO_DEPTH      = 4
) (
  input  logic clk,
  input  logic rst_n,
  input  logic pll_locked,
  input  key_t key,
  input  sw_t  sw,
  output seg_t hex0,
  output seg_t hex1,
  output seg_t hex2,
  output seg_t hex3,
  output seg_t hex4,
  output seg_t hex5,
  output led_t ledr
);

  logic      sys_rst_n;
  logic      cmd_valid;
  logic      credit_return;
  logic [2:0] press;
  cmd_op_t   cmd_op;
  arg_t      cmd_arg;
  drop_cnt_t drop_cnt;

  // key[3] doubles as the reset button
  reset_sync u_reset_sync (
    .clk          (clk),
    .rst_n        (rst_n),
    .button_rst_n (key[3]),
    .pll_locked   (pll_locked),
    .sys_rst_n    (sys_rst_n)
  );

  // key0 shift, key1 add, key2 clear
  for (genvar i = 0; i < 3; i++) begin : g_key
    key_debounce #(
      .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
    ) u_key_debounce (
      .clk   (clk),
      .rst_n (sys_rst_n),
      .key_n (key[i]),
      .press (press[i])
    );
  end

  cmd_issuer #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_cmd_issuer (
    .clk           (clk),
    .rst_n         (sys_rst_n),
    .press_shift   (press[0]),
    .press_add     (press[1]),
    .press_clear   (press[2]),
    .sw            (sw),
    .credit_return (credit_return),
    .cmd_valid     (cmd_valid),
    .cmd_op        (cmd_op),
    .cmd_arg       (cmd_arg),
    .drop_cnt      (drop_cnt)
  );

  // sw[9] holds the queue
  display_engine #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_display_engine (
    .clk           (clk),
    .rst_n         (sys_rst_n),
    .freeze        (sw[9]),
    .cmd_valid     (cmd_valid),
    .cmd_op        (cmd_op),
    .cmd_arg       (cmd_arg),
    .drop_cnt      (drop_cnt),
    .credit_return (credit_return),
    .hex0          (hex0),
    .hex1          (hex1),
    .hex2          (hex2),
    .hex3          (hex3),
    .hex4          (hex4),
    .hex5          (hex5),
    .ledr          (ledr)
  );

endmodule

/* verif/tb_clock_gen.sv */
// Testbench clock and reset
`timescale 1ns/10ps

module tb_clock_gen #(
  parameter int PERIOD_NS    = 20,
  parameter int RESET_CYCLES = 2
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  // Reset held low for the first few rising edges
  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule

/* verif/tb_board_top.sv */
// Board subsystem testbench
`timescale 1ns/10ps

module tb_board_top import board_pkg::*; ();

  // 29 presses of about 31 cycles each take roughly 900 cycles
  localparam int TIMEOUT_CYCLES = 4000;

  logic   clk;
  logic   rst_n;
  logic   pll_locked;
  key_t   key;
  sw_t    sw;
  seg_t   hex0, hex1, hex2, hex3, hex4, hex5;
  led_t   ledr;

  value_t model_value;
  int     exp_drops;
  integer seed;
  int     cycle_cnt;

  // Active low gfedcba glyphs for 0 to F
  logic [6:0] glyph [16] = '{
    7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
    7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0e
  };

  tb_clock_gen #(.PERIOD_NS(20), .RESET_CYCLES(2)) u_tb_clock_gen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  board_top #(.DEBOUNCE_CYCLES(4), .FIFO_DEPTH(4)) u_board_top (
    .clk        (clk),
    .rst_n      (rst_n),
    .pll_locked (pll_locked),
    .key        (key),
    .sw         (sw),
    .hex0       (hex0),
    .hex1       (hex1),
    .hex2       (hex2),
    .hex3       (hex3),
    .hex4       (hex4),
    .hex5       (hex5),
    .ledr       (ledr)
  );

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == TIMEOUT_CYCLES) begin
      $display("TESTBENCH FAILED");
      $fatal(1, "timeout, the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
    end
  end

  // ==================================================
  // Checking helpers
  // ==================================================
  task automatic compare(input string name, input logic [63:0] expected,
                         input logic [63:0] actual);
    if (expected !== actual) begin
      $display("mismatch %s: expected %0h actual %0h", name, expected, actual);
      $display("TESTBENCH FAILED");
      $fatal(1, "value check failed in %s", name);
    end
  endtask

  function automatic logic [41:0] expected_hex(input value_t v);
    return {glyph[v[23:20]], glyph[v[19:16]], glyph[v[15:12]],
            glyph[v[11:8]], glyph[v[7:4]], glyph[v[3:0]]};
  endfunction

  // Sampled mid cycle, away from the driving edge
  task automatic check_display(input string name);
    @(negedge clk);
    compare(name, 64'(expected_hex(model_value)),
            64'({hex5, hex4, hex3, hex2, hex1, hex0}));
  endtask

  task automatic check_leds(input string name, input led_t expected);
    @(negedge clk);
    compare(name, 64'(expected), 64'(ledr));
  endtask

  task automatic press_key(input int idx, input logic [7:0] arg);
    @(posedge clk);
    sw[7:0] <= arg;
    key     <= key & ~(4'b0001 << idx);
    repeat (10) @(posedge clk);
    key     <= key | (4'b0001 << idx);
    repeat (10) @(posedge clk);
    repeat (10) @(posedge clk);
  endtask

  task automatic shift_model(input logic [3:0] nib);
    model_value = {model_value[19:0], nib};
  endtask

  // ==================================================
  // Directed tests
  // ==================================================
  task automatic test_reset_state();
    wait (rst_n === 1'b1);
    repeat (3) @(posedge clk);
    check_display("reset_state");
    check_leds("reset_state", '0);
  endtask

  task automatic test_shift();
    logic [3:0] nib;
    for (int i = 0; i < 7; i++) begin
      nib = 4'($random(seed));
      press_key(0, {4'h0, nib});
      shift_model(nib);
      check_display("shift");
    end
  endtask

  task automatic test_add();
    logic [7:0] arg;
    for (int i = 0; i < 4; i++) begin
      arg = 8'($random(seed));
      press_key(1, arg);
      model_value = model_value + value_t'(arg);
      check_display("add");
    end
    // Load FFFFFF so the next adds wrap
    for (int i = 0; i < 6; i++) begin
      press_key(0, 8'h0f);
      shift_model(4'hf);
    end
    check_display("add_preload");
    for (int i = 0; i < 2; i++) begin
      arg = 8'($random(seed)) | 8'h01;
      press_key(1, arg);
      model_value = model_value + value_t'(arg);
      check_display("add_wrap");
    end
  endtask

  task automatic test_clear();
    press_key(2, 8'h5a);
    model_value = '0;
    check_display("clear");
    check_leds("clear", {2'b00, 8'(exp_drops)});
  endtask

  task automatic test_freeze();
    @(posedge clk);
    sw[9] <= 1'b1;
    for (int i = 0; i < 6; i++) begin
      press_key(0, 8'(i + 1));
    end
    // Four credits, so presses five and six are dropped
    exp_drops = exp_drops + 2;
    check_display("freeze_hold");
    check_leds("freeze_hold", {2'b11, 8'(exp_drops)});

    @(posedge clk);
    sw[9] <= 1'b0;
    // One pop per cycle drains the four queued commands
    repeat (6) @(posedge clk);
    for (int i = 0; i < 4; i++) begin
      shift_model(4'(i + 1));
    end
    check_display("freeze_release");
    check_leds("freeze_release", {2'b00, 8'(exp_drops)});

    press_key(0, 8'h07);
    shift_model(4'h7);
    check_display("freeze_credit");
  endtask

  task automatic test_reset_sources();
    press_key(0, 8'h0c);
    shift_model(4'hc);
    check_display("reset_key3_setup");

    @(posedge clk);
    key <= key & 4'b0111;
    repeat (2) @(posedge clk);
    key <= key | 4'b1000;
    repeat (4) @(posedge clk);
    model_value = '0;
    exp_drops   = 0;
    check_display("reset_key3");
    check_leds("reset_key3", '0);

    press_key(0, 8'h09);
    shift_model(4'h9);
    check_display("reset_pll_setup");

    @(posedge clk);
    pll_locked <= 1'b0;
    repeat (2) @(posedge clk);
    pll_locked <= 1'b1;
    repeat (4) @(posedge clk);
    model_value = '0;
    check_display("reset_pll");
    check_leds("reset_pll", '0);
  endtask

  initial begin
    pll_locked  = 1'b1;
    key         = 4'hf;
    sw          = '0;
    model_value = '0;
    exp_drops   = 0;
    seed        = 39;
    cycle_cnt   = 0;

    test_reset_state();
    test_shift();
    test_add();
    test_freeze();
    test_clear();
    test_reset_sources();

    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

/* filelist.f */
src/board_pkg.sv
src/hex_decoder.sv
src/reset_sync.sv
src/key_debounce.sv
src/cmd_issuer.sv
src/display_engine.sv
src/board_top.sv
verif/tb_clock_gen.sv
verif/tb_board_top.sv

/* Makefile */
BUILD_DIR = obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal --top-module tb_board_top \
		-Mdir $(BUILD_DIR) -f filelist.f

run: compile
	./$(BUILD_DIR)/Vtb_board_top

clean:
	rm -rf $(BUILD_DIR)
